//--- verilog/lsu_settings.svh
//////////////////////////////////////////////////////////////////////
// LSU_VREG_W must be a whole multiple of LSU_VMEM_W, with at least 2 beats
// LSU_VMEM_W is a power of two of 32 bits or more
//////////////////////////////////////////////////////////////////////

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// vector register width in bits
`define LSU_VREG_W 128

// memory port width in bits
`define LSU_VMEM_W 32

// memory beats needed to move one register
`define LSU_BEATS (`LSU_VREG_W / `LSU_VMEM_W)

// width of the vector length in elements
`define LSU_VL_W 8

`endif

//--- verilog/lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the vector LSU, all sizes come from lsu_settings.svh
//////////////////////////////////////////////////////////////////////

`include "lsu_settings.svh"

package lsu_pkg;

    // bytes in one vector register
    localparam int unsigned VMSK_W = `LSU_VREG_W / 8;

    typedef logic [`LSU_VREG_W-1:0]       vreg_t;
    typedef logic [VMSK_W-1:0]            vmsk_t;
    typedef logic [`LSU_VMEM_W-1:0]       mem_word_t;
    typedef logic [`LSU_VMEM_W/8-1:0]     mem_be_t;
    typedef logic [31:0]                  addr_t;
    typedef logic [`LSU_VL_W-1:0]         vl_t;
    typedef logic [4:0]                   vaddr_t;
    typedef logic [$clog2(`LSU_BEATS)-1:0] beat_cnt_t;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_REQ  = 1'b1
    } lsu_state_e;

    // bytes below vl * element bytes are set, saturating at a full register
    function automatic vmsk_t vl_byte_mask(eew_e eew, vl_t vl);
        logic [`LSU_VL_W+1:0] nbytes;
        vmsk_t                mask;
        case (eew)
            EEW_16:  nbytes = {1'b0, vl, 1'b0};
            EEW_32:  nbytes = {vl, 2'b00};
            default: nbytes = {2'b00, vl};
        endcase
        for (int i = 0; i < VMSK_W; i++) begin
            mask[i] = (nbytes > i);
        end
        return mask;
    endfunction

endpackage

//--- verilog/lsu_addr_gen.sv
//////////////////////////////////////////////////////////////////////
// takes one operation at a time, the base address is rounded down to a word
// the request stays up until granted, one beat per grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_settings.svh"

module lsu_addr_gen (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               op_valid_i,
    input  logic               op_store_i,
    input  lsu_pkg::eew_e      op_eew_i,
    input  lsu_pkg::vl_t       op_vl_i,
    input  lsu_pkg::addr_t     op_base_i,
    input  lsu_pkg::vaddr_t    op_vd_i,
    input  logic               data_gnt_i,
    input  logic               load_busy_i,
    output logic               op_ready_o,
    output logic               accept_o,
    output logic               data_req_o,
    output lsu_pkg::addr_t     data_addr_o,
    output logic               data_we_o,
    output logic               beat_done_o,
    output lsu_pkg::beat_cnt_t beat_idx_o,
    output logic               store_op_o,
    output lsu_pkg::eew_e      load_eew_o,
    output lsu_pkg::vl_t       load_vl_o,
    output lsu_pkg::vaddr_t    load_vd_o
);

    localparam lsu_pkg::addr_t     WORD_BYTES = lsu_pkg::addr_t'(`LSU_VMEM_W / 8);
    localparam lsu_pkg::beat_cnt_t LAST_BEAT  = lsu_pkg::beat_cnt_t'(`LSU_BEATS - 1);

    lsu_pkg::lsu_state_e state_q, state_d;
    lsu_pkg::beat_cnt_t  beat_q;
    lsu_pkg::addr_t      addr_q;
    logic                store_q;
    lsu_pkg::eew_e       eew_q;
    lsu_pkg::vl_t        vl_q;
    lsu_pkg::vaddr_t     vd_q;
    logic                last_beat;

    // a new operation waits until the read data of a load is written back
    assign op_ready_o  = (state_q == lsu_pkg::ST_IDLE) & ~load_busy_i;
    assign accept_o    = op_valid_i & op_ready_o;
    assign data_req_o  = (state_q == lsu_pkg::ST_REQ);
    assign beat_done_o = data_req_o & data_gnt_i;
    assign last_beat   = (beat_q == LAST_BEAT);

    //////////////////////////////////////////////////////////////////////
    // request FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::ST_IDLE: begin
                if (accept_o) begin
                    state_d = lsu_pkg::ST_REQ;
                end
            end
            lsu_pkg::ST_REQ: begin
                if (beat_done_o && last_beat) begin
                    state_d = lsu_pkg::ST_IDLE;
                end
            end
            default: state_d = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= lsu_pkg::ST_IDLE;
            beat_q  <= '0;
            store_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept_o) begin
                beat_q  <= '0;
                store_q <= op_store_i;
            end else if (beat_done_o) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operation fields and address

    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            addr_q <= op_base_i & ~(WORD_BYTES - 1'b1);
            eew_q  <= op_eew_i;
            vl_q   <= op_vl_i;
            vd_q   <= op_vd_i;
        end else if (beat_done_o) begin
            addr_q <= addr_q + WORD_BYTES;
        end
    end

    assign data_addr_o = addr_q;
    assign data_we_o   = store_q;
    assign beat_idx_o  = beat_q;
    assign store_op_o  = store_q;

    // held until the next accept, which cannot come before writeback
    assign load_eew_o  = eew_q;
    assign load_vl_o   = vl_q;
    assign load_vd_o   = vd_q;

endmodule

//--- verilog/lsu_store_data.sv
//////////////////////////////////////////////////////////////////////
// the store operand is captured from the register file on accept
// lowest word goes out first, bytes past the tail get zero enables
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_settings.svh"

module lsu_store_data (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               accept_i,
    input  lsu_pkg::eew_e      op_eew_i,
    input  lsu_pkg::vl_t       op_vl_i,
    input  lsu_pkg::vreg_t     vreg_rd_i,
    input  logic               beat_done_i,
    input  lsu_pkg::beat_cnt_t beat_idx_i,
    output lsu_pkg::mem_word_t data_wdata_o,
    output lsu_pkg::mem_be_t   data_be_o
);

    localparam lsu_pkg::beat_cnt_t LAST_BEAT = lsu_pkg::beat_cnt_t'(`LSU_BEATS - 1);

    lsu_pkg::vreg_t wdata_q;
    lsu_pkg::vmsk_t be_q;
    logic           last_beat;

    assign last_beat = (beat_idx_i == LAST_BEAT);

    // byte mask of the whole register, shifted along with the data
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            be_q <= '0;
        end else if (accept_i) begin
            be_q <= lsu_pkg::vl_byte_mask(op_eew_i, op_vl_i);
        end else if (beat_done_i) begin
            if (last_beat) begin
                be_q <= '0;
            end else begin
                be_q <= be_q >> (`LSU_VMEM_W / 8);
            end
        end
    end

    // operand shift register, nothing left to shift after the last grant
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            wdata_q <= vreg_rd_i;
        end else if (beat_done_i && !last_beat) begin
            wdata_q <= wdata_q >> `LSU_VMEM_W;
        end
    end

    assign data_wdata_o = wdata_q[`LSU_VMEM_W-1:0];
    assign data_be_o    = be_q[`LSU_VMEM_W/8-1:0];

endmodule

//--- verilog/lsu_load_data.sv
//////////////////////////////////////////////////////////////////////
// read data must arrive in request order, it cannot be stalled
// the register is written once, one cycle after the last beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_settings.svh"

module lsu_load_data (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               accept_i,
    input  logic               store_i,
    input  lsu_pkg::eew_e      load_eew_i,
    input  lsu_pkg::vl_t       load_vl_i,
    input  lsu_pkg::vaddr_t    load_vd_i,
    input  logic               data_rvalid_i,
    input  lsu_pkg::mem_word_t data_rdata_i,
    output logic               load_busy_o,
    output logic               vreg_wr_en_o,
    output lsu_pkg::vaddr_t    vreg_wr_addr_o,
    output lsu_pkg::vmsk_t     vreg_wr_mask_o,
    output lsu_pkg::vreg_t     vreg_wr_o
);

    localparam lsu_pkg::beat_cnt_t LAST_BEAT = lsu_pkg::beat_cnt_t'(`LSU_BEATS - 1);

    logic               busy_q;
    logic               wr_en_q;
    lsu_pkg::beat_cnt_t cnt_q;
    lsu_pkg::vreg_t     shift_q;
    logic               rd_beat;
    logic               last_rd_beat;

    // beats only count while waiting for data, not during writeback
    assign rd_beat      = busy_q & ~wr_en_q & data_rvalid_i;
    assign last_rd_beat = rd_beat & (cnt_q == LAST_BEAT);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q  <= 1'b0;
            wr_en_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            wr_en_q <= last_rd_beat;
            if (accept_i && !store_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (wr_en_q) begin
                busy_q <= 1'b0;
            end else if (rd_beat) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // destination assembly

    // each word enters at the top, so the first beat ends up in the low word
    always_ff @(posedge clk_i) begin
        if (rd_beat) begin
            shift_q <= {data_rdata_i, shift_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
        end
    end

    assign load_busy_o    = busy_q;
    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = load_vd_i;
    assign vreg_wr_mask_o = lsu_pkg::vl_byte_mask(load_eew_i, load_vl_i);
    assign vreg_wr_o      = shift_q;

endmodule

//--- verilog/lsu_top.sv
//////////////////////////////////////////////////////////////////////
// unit-stride vector load/store unit, one operation in flight at a time
// register file read is asynchronous and addressed straight from the issue side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_top (
    input  logic               clk_i,
    input  logic               async_rst_ni,

    // issue side
    input  logic               op_valid_i,
    output logic               op_ready_o,
    input  logic               op_store_i,
    input  lsu_pkg::eew_e      op_eew_i,
    input  lsu_pkg::vl_t       op_vl_i,
    input  lsu_pkg::addr_t     op_base_i,
    input  lsu_pkg::vaddr_t    op_vd_i,

    // register file
    output lsu_pkg::vaddr_t    vreg_rd_addr_o,
    input  lsu_pkg::vreg_t     vreg_rd_i,
    output logic               vreg_wr_en_o,
    output lsu_pkg::vaddr_t    vreg_wr_addr_o,
    output lsu_pkg::vmsk_t     vreg_wr_mask_o,
    output lsu_pkg::vreg_t     vreg_wr_o,

    // memory
    output logic               data_req_o,
    output lsu_pkg::addr_t     data_addr_o,
    output logic               data_we_o,
    output lsu_pkg::mem_be_t   data_be_o,
    output lsu_pkg::mem_word_t data_wdata_o,
    input  logic               data_gnt_i,
    input  logic               data_rvalid_i,
    input  lsu_pkg::mem_word_t data_rdata_i
);

    logic               accept;
    logic               beat_done;
    lsu_pkg::beat_cnt_t beat_idx;
    logic               store_op;
    lsu_pkg::eew_e      load_eew;
    lsu_pkg::vl_t       load_vl;
    lsu_pkg::vaddr_t    load_vd;
    logic               load_busy;

    // store operand is read in the accept cycle
    assign vreg_rd_addr_o = op_vd_i;

    lsu_addr_gen lsu_addr_gen_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_valid_i   (op_valid_i),
        .op_store_i   (op_store_i),
        .op_eew_i     (op_eew_i),
        .op_vl_i      (op_vl_i),
        .op_base_i    (op_base_i),
        .op_vd_i      (op_vd_i),
        .data_gnt_i   (data_gnt_i),
        .load_busy_i  (load_busy),
        .op_ready_o   (op_ready_o),
        .accept_o     (accept),
        .data_req_o   (data_req_o),
        .data_addr_o  (data_addr_o),
        .data_we_o    (data_we_o),
        .beat_done_o  (beat_done),
        .beat_idx_o   (beat_idx),
        .store_op_o   (store_op),
        .load_eew_o   (load_eew),
        .load_vl_o    (load_vl),
        .load_vd_o    (load_vd)
    );

    // store data only advances on granted store beats
    lsu_store_data lsu_store_data_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .accept_i     (accept),
        .op_eew_i     (op_eew_i),
        .op_vl_i      (op_vl_i),
        .vreg_rd_i    (vreg_rd_i),
        .beat_done_i  (beat_done & store_op),
        .beat_idx_i   (beat_idx),
        .data_wdata_o (data_wdata_o),
        .data_be_o    (data_be_o)
    );

    lsu_load_data lsu_load_data_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .accept_i       (accept),
        .store_i        (op_store_i),
        .load_eew_i     (load_eew),
        .load_vl_i      (load_vl),
        .load_vd_i      (load_vd),
        .data_rvalid_i  (data_rvalid_i),
        .data_rdata_i   (data_rdata_i),
        .load_busy_o    (load_busy),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o),
        .vreg_wr_o      (vreg_wr_o)
    );

endmodule

//--- sim/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// free-running 40 ns clock, reset held low for the first 4 rising edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_no
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // released just after an edge, like every other testbench drive
    initial begin
        rst_no = 1'b0;
        repeat (4) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

//--- sim/lsu_sva.sv
//////////////////////////////////////////////////////////////////////
// protocol properties of the LSU memory and writeback ports
// fail_count is read by the testbench at the end of the run
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lsu_sva (
    input logic               clk_i,
    input logic               async_rst_ni,
    input logic               op_ready_o,
    input logic               data_req_o,
    input logic               data_gnt_i,
    input lsu_pkg::addr_t     data_addr_o,
    input logic               data_we_o,
    input lsu_pkg::mem_be_t   data_be_o,
    input lsu_pkg::mem_word_t data_wdata_o,
    input logic               vreg_wr_en_o
);

    int unsigned fail_count = 0;

    // an ungranted request keeps all of its fields
    req_hold_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
            && $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o))
    else begin
        fail_count++;
        $error("memory request changed before it was granted");
    end

    wr_pulse_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_en_o |=> !vreg_wr_en_o)
    else begin
        fail_count++;
        $error("register write enable high for two cycles");
    end

    // no new operation while a request or a register write is out
    ready_idle_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (data_req_o || vreg_wr_en_o) |-> !op_ready_o)
    else begin
        fail_count++;
        $error("ready asserted while a memory request or register write is pending");
    end

    reset_quiet_a: assert property (@(posedge clk_i)
        $rose(async_rst_ni) |-> !data_req_o && !vreg_wr_en_o)
    else begin
        fail_count++;
        $error("request or register write active right after reset");
    end

endmodule

bind lsu_top lsu_sva lsu_sva_i (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .op_ready_o   (op_ready_o),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_addr_o  (data_addr_o),
    .data_we_o    (data_we_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .vreg_wr_en_o (vreg_wr_en_o)
);

//--- sim/tb_top.sv
//////////////////////////////////////////////////////////////////////
// memory model holds 64 words and wraps above that, bases stay word aligned
// grants come 0 to 3 cycles after a request, read data 1 to 3 cycles after
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_settings.svh"

module tb_top;

    localparam int unsigned VREG_BYTES = `LSU_VREG_W / 8;
    localparam int unsigned WORD_BYTES = `LSU_VMEM_W / 8;
    localparam int unsigned MEM_WORDS  = 64;
    localparam int          WAIT_LIMIT = 200;

    logic               clk_i;
    logic               async_rst_ni;
    logic               op_valid_i;
    logic               op_ready_o;
    logic               op_store_i;
    lsu_pkg::eew_e      op_eew_i;
    lsu_pkg::vl_t       op_vl_i;
    lsu_pkg::addr_t     op_base_i;
    lsu_pkg::vaddr_t    op_vd_i;
    lsu_pkg::vaddr_t    vreg_rd_addr_o;
    lsu_pkg::vreg_t     vreg_rd_i;
    logic               vreg_wr_en_o;
    lsu_pkg::vaddr_t    vreg_wr_addr_o;
    lsu_pkg::vmsk_t     vreg_wr_mask_o;
    lsu_pkg::vreg_t     vreg_wr_o;
    logic               data_req_o;
    lsu_pkg::addr_t     data_addr_o;
    logic               data_we_o;
    lsu_pkg::mem_be_t   data_be_o;
    lsu_pkg::mem_word_t data_wdata_o;
    logic               data_gnt_i;
    logic               data_rvalid_i;
    lsu_pkg::mem_word_t data_rdata_i;

    // models, their expected images and the read return queue
    lsu_pkg::mem_word_t mem [MEM_WORDS];
    lsu_pkg::mem_word_t exp_mem [MEM_WORDS];
    lsu_pkg::vreg_t     rf [32];
    lsu_pkg::vreg_t     exp_rf [32];
    lsu_pkg::mem_word_t rd_data_q [$];
    int unsigned        rd_cycle_q [$];
    int unsigned        cycle = 0;
    int unsigned        last_rd_cycle = 0;
    int unsigned        gnt_wait;
    int unsigned        gnt_count;
    int unsigned        wr_count;
    lsu_pkg::addr_t     exp_addr;
    logic               exp_we;
    lsu_pkg::vmsk_t     exp_wr_mask;
    lsu_pkg::vaddr_t    exp_wr_vd;
    logic [31:0]        lcg_state;
    int unsigned        mismatches = 0;
    int unsigned        timeouts = 0;

    tb_clock tb_clock_i (
        .clk_o  (clk_i),
        .rst_no (async_rst_ni)
    );

    lsu_top lsu_top_i (.*);

    assign vreg_rd_i = rf[vreg_rd_addr_o];

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    // bytes covered by vl elements, at most one register
    function automatic int unsigned tail_bytes(input lsu_pkg::eew_e eew, input lsu_pkg::vl_t vl);
        int unsigned n;
        n = int'(vl) << int'(eew);
        return (n > VREG_BYTES) ? VREG_BYTES : n;
    endfunction

    task automatic expect_equal(input logic [`LSU_VREG_W-1:0] got,
                                input logic [`LSU_VREG_W-1:0] exp, input string what);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory and register file models

    // sampled mid-cycle, where every DUT output has settled
    always @(negedge clk_i) begin : sample_ports
        int unsigned w;
        int unsigned rd_at;
        cycle++;
        if (async_rst_ni && data_req_o && data_gnt_i) begin
            gnt_count++;
            expect_equal(data_addr_o, exp_addr, "request address");
            expect_equal(data_we_o, exp_we, "request write enable");
            exp_addr += WORD_BYTES;
            w = (data_addr_o / WORD_BYTES) % MEM_WORDS;
            if (data_we_o) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (data_be_o[b]) begin
                        mem[w][8*b +: 8] = data_wdata_o[8*b +: 8];
                    end
                end
            end else begin
                // in order, one per cycle, 1 to 3 cycles after the grant
                rd_at = cycle + 1 + rand_below(3);
                if (rd_at > last_rd_cycle) begin
                    last_rd_cycle = rd_at;
                end
                rd_data_q.push_back(mem[w]);
                rd_cycle_q.push_back(last_rd_cycle);
                last_rd_cycle++;
            end
            gnt_wait = rand_below(4);
        end
        if (vreg_wr_en_o) begin
            wr_count++;
            expect_equal(vreg_wr_addr_o, exp_wr_vd, "writeback register number");
            expect_equal(vreg_wr_mask_o, exp_wr_mask, "writeback byte mask");
            for (int b = 0; b < VREG_BYTES; b++) begin
                if (vreg_wr_mask_o[b]) begin
                    rf[vreg_wr_addr_o][8*b +: 8] = vreg_wr_o[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk_i) begin : drive_memory
        logic gnt;
        logic rvalid;
        #1;
        gnt = 1'b0;
        rvalid = 1'b0;
        if (async_rst_ni && data_req_o) begin
            if (gnt_wait == 0) begin
                gnt = 1'b1;
            end else begin
                gnt_wait--;
            end
        end
        if (async_rst_ni && rd_cycle_q.size() > 0 && rd_cycle_q[0] <= cycle + 1) begin
            rvalid = 1'b1;
            data_rdata_i = rd_data_q.pop_front();
            void'(rd_cycle_q.pop_front());
        end
        data_gnt_i    = gnt;
        data_rvalid_i = rvalid;
    end

    //////////////////////////////////////////////////////////////////////
    // operations

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (!op_ready_o && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (!op_ready_o) begin
            timeouts++;
            $display("timeout at %0t ns: the LSU did not become ready %s", $time, what);
        end
    endtask

    task automatic issue_op(input logic store, input lsu_pkg::eew_e eew, input lsu_pkg::vl_t vl,
                            input lsu_pkg::addr_t base, input lsu_pkg::vaddr_t vd);
        wait_ready("for a new operation");
        op_valid_i = 1'b1;
        op_store_i = store;
        op_eew_i   = eew;
        op_vl_i    = vl;
        op_base_i  = base;
        op_vd_i    = vd;
        @(posedge clk_i);
        #1;
        op_valid_i = 1'b0;
        wait_ready("after an operation");
    endtask

    task automatic run_store(input lsu_pkg::vaddr_t vd, input lsu_pkg::eew_e eew,
                             input lsu_pkg::vl_t vl, input lsu_pkg::addr_t base);
        int unsigned w;
        for (int b = 0; b < tail_bytes(eew, vl); b++) begin
            w = (base / WORD_BYTES + b / WORD_BYTES) % MEM_WORDS;
            exp_mem[w][8*(b % WORD_BYTES) +: 8] = exp_rf[vd][8*b +: 8];
        end
        exp_we    = 1'b1;
        exp_addr  = base;
        gnt_count = 0;
        wr_count  = 0;
        issue_op(1'b1, eew, vl, base, vd);
        expect_equal(gnt_count, `LSU_BEATS, "granted store beats");
        expect_equal(wr_count, 0, "register writes during a store");
        for (int i = 0; i < MEM_WORDS; i++) begin
            expect_equal(mem[i], exp_mem[i], $sformatf("memory word %0d", i));
        end
    endtask

    task automatic run_load(input lsu_pkg::vaddr_t vd, input lsu_pkg::eew_e eew,
                            input lsu_pkg::vl_t vl, input lsu_pkg::addr_t base);
        int unsigned w;
        exp_wr_mask = '0;
        for (int b = 0; b < tail_bytes(eew, vl); b++) begin
            w = (base / WORD_BYTES + b / WORD_BYTES) % MEM_WORDS;
            exp_wr_mask[b] = 1'b1;
            exp_rf[vd][8*b +: 8] = exp_mem[w][8*(b % WORD_BYTES) +: 8];
        end
        exp_we    = 1'b0;
        exp_addr  = base;
        exp_wr_vd = vd;
        gnt_count = 0;
        wr_count  = 0;
        issue_op(1'b0, eew, vl, base, vd);
        expect_equal(gnt_count, `LSU_BEATS, "granted load beats");
        expect_equal(wr_count, 1, "register writebacks of a load");
        expect_equal(rf[vd], exp_rf[vd], $sformatf("loaded register %0d", vd));
    endtask

    function automatic lsu_pkg::addr_t rand_base();
        return (rand_below(MEM_WORDS - `LSU_BEATS + 1)) * WORD_BYTES;
    endfunction

    initial begin : stimulus
        int n;
        int unsigned src;
        int unsigned dst;
        int unsigned sva_fails;
        lsu_pkg::addr_t base;
        lsu_pkg::eew_e eew;
        lcg_state     = 32'd15449;
        op_valid_i    = 1'b0;
        op_store_i    = 1'b0;
        op_eew_i      = lsu_pkg::EEW_8;
        op_vl_i       = '0;
        op_base_i     = '0;
        op_vd_i       = '0;
        data_gnt_i    = 1'b0;
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = 32'h5a3c_0000 ^ (i * 32'h0103_0507 + 32'h0000_1357);
            exp_mem[i] = mem[i];
        end
        for (int r = 0; r < 32; r++) begin
            for (int k = 0; k < `LSU_VREG_W / 32; k++) begin
                rf[r][32*k +: 32] = (rand_below(65536) << 16) | rand_below(65536);
            end
            exp_rf[r] = rf[r];
        end
        gnt_wait = rand_below(4);

        n = 0;
        while (async_rst_ni !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (async_rst_ni !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t ns: reset was never released", $time);
        end
        expect_equal(op_ready_o, 1'b1, "ready after reset");

        // whole register, then a vl far past the register end
        run_store(5'd3, lsu_pkg::EEW_8, 8'd16, 32'h40);
        run_store(5'd4, lsu_pkg::EEW_32, 8'd200, 32'h80);

        for (int e = 0; e < 3; e++) begin
            eew = lsu_pkg::eew_e'(e);
            run_store(rand_below(32), eew, 1 + rand_below((VREG_BYTES >> e) - 1), rand_base());
        end

        run_load(5'd10, lsu_pkg::EEW_32, 8'd4, 32'h40);
        for (int e = 0; e < 3; e++) begin
            eew = lsu_pkg::eew_e'(e);
            run_load(rand_below(32), eew, 1 + rand_below((VREG_BYTES >> e) - 1), rand_base());
        end

        // round trips through memory
        for (int i = 0; i < 8; i++) begin
            src  = rand_below(32);
            dst  = (src + 1 + rand_below(31)) % 32;
            base = rand_base();
            eew  = lsu_pkg::eew_e'(rand_below(3));
            run_store(src, eew, (VREG_BYTES >> eew) + rand_below(8), base);
            run_load(dst, lsu_pkg::EEW_8, 8'd255, base);
            expect_equal(rf[dst], rf[src], "register after a store and a load back");
        end

        sva_fails = lsu_top_i.lsu_sva_i.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, sva_fails);
        if (mismatches == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_store_data.sv
verilog/lsu_load_data.sv
verilog/lsu_top.sv
sim/tb_clock.sv
sim/lsu_sva.sv
sim/tb_top.sv
